// File: sources.f
hw/videoPkg.sv
hw/vgaTiming.sv
hw/rectDrawer.sv
hw/backgroundGen.sv
hw/objectsMux.sv
hw/videoTop.sv
bench/video_checker.sv
bench/videoTopTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the video testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f sources.f --top-module videoTopTb --Mdir build -o simv > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./build/simv > sim.log 2>&1
cat sim.log

grep -q "Everything OK" sim.log && exit 0 || exit 1

// File: bench/videoTopTb.sv
// ==============================
// video top testbench
// directed frames against an image model,
// sync timing, priority and blanking
// ==============================
`default_nettype none

module videoTopTb;
	timeunit 1ns;
	timeprecision 1ns;
	import videoPkg::*;

	// small geometry keeps a frame short
	localparam int hActive = 64;
	localparam int hFront = 4;
	localparam int hSyncLen = 8;
	localparam int hBack = 4;
	localparam int vActive = 48;
	localparam int vFront = 2;
	localparam int vSyncLen = 2;
	localparam int vBack = 2;
	localparam int numObjects = 3;
	localparam int gridSpacing = 16;
	localparam int hTotal = hActive + hFront + hSyncLen + hBack;
	localparam int vTotal = vActive + vFront + vSyncLen + vBack;
	localparam int frameCycles = hTotal * vTotal;
	// pixel to output latency
	localparam int pipeDelay = 2;

	logic clk;
	logic resetN;
	pixelPosT objTopLeft [numObjects];
	pixelPosT objSize [numObjects];
	rgb8T objColor [numObjects];
	rgb8T gridColor;
	rgb8T fillColor;
	logic hSync;
	logic vSync;
	logic frameStart;
	rgb24T rgbOut;

	int mismatches;
	int otherErrors;
	integer seed;

	videoTop #(
		.hActive(hActive),
		.hFront(hFront),
		.hSyncLen(hSyncLen),
		.hBack(hBack),
		.vActive(vActive),
		.vFront(vFront),
		.vSyncLen(vSyncLen),
		.vBack(vBack),
		.numObjects(numObjects),
		.gridSpacing(gridSpacing)
	) dut (
		.clk(clk),
		.resetN(resetN),
		.objTopLeft(objTopLeft),
		.objSize(objSize),
		.objColor(objColor),
		.gridColor(gridColor),
		.fillColor(fillColor),
		.hSync(hSync),
		.vSync(vSync),
		.frameStart(frameStart),
		.rgbOut(rgbOut)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// RGB332 widened to 24 bits by repeating each channel's low bit
	function automatic rgb24T expand(rgb8T c);
		rgb24T e;
		e.red = {c[7:5], (c[5] ? 5'b11111 : 5'b00000)};
		e.green = {c[4:2], (c[2] ? 5'b11111 : 5'b00000)};
		e.blue = {c[1:0], (c[0] ? 6'b111111 : 6'b000000)};
		return e;
	endfunction

	// expected output colour at one scan position
	function automatic rgb24T modelPixel(int col, int row);
		rgb8T c;
		logic found;
		int left;
		int top;
		found = 1'b0;
		if (col >= hActive || row >= vActive) begin
			return '0;
		end
		if ((col % gridSpacing) == 0 || (row % gridSpacing) == 0) begin
			c = gridColor;
		end else begin
			c = fillColor;
		end
		// first hit from index 0 wins
		for (int i = 0; i < numObjects; i++) begin
			left = int'(objTopLeft[i].x);
			top = int'(objTopLeft[i].y);
			if (!found && col >= left && col < left + int'(objSize[i].x)
					&& row >= top && row < top + int'(objSize[i].y)) begin
				c = objColor[i];
				found = 1'b1;
			end
		end
		return expand(c);
	endfunction

	// called right after a rising edge
	task automatic placeObject(int idx, int posX, int posY, int width, int height, rgb8T c);
		objTopLeft[idx] <= '{x: coordT'(posX), y: coordT'(posY)};
		objSize[idx] <= '{x: coordT'(width), y: coordT'(height)};
		objColor[idx] <= c;
	endtask

	task automatic clearObjects();
		for (int i = 0; i < numObjects; i++) begin
			placeObject(i, 0, 0, 0, 0, 8'h00);
		end
	endtask

	function automatic int randBelow(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// one whole frame against the model including sync
	task automatic scanFrame(string testName);
		int waited;
		int col;
		int row;
		rgb24T expRgb;
		logic expH;
		logic expV;
		waited = 0;
		// new inputs must clear the pipeline first
		repeat (pipeDelay + 1) @(posedge clk);
		@(negedge clk);
		while (frameStart !== 1'b1 && waited < frameCycles + 10) begin
			@(negedge clk);
			waited++;
		end
		if (frameStart !== 1'b1) begin
			$display("%s: frameStart never arrived within %0d cycles", testName, waited);
			otherErrors++;
			return;
		end
		for (int k = 0; k < frameCycles; k++) begin
			col = k % hTotal;
			row = k / hTotal;
			expRgb = modelPixel(col, row);
			expH = !(col >= hActive + hFront && col < hActive + hFront + hSyncLen);
			expV = !(row >= vActive + vFront && row < vActive + vFront + vSyncLen);
			if (rgbOut !== expRgb) begin
				$display("MISMATCH %s rgbOut at (%0d,%0d): expected %h, actual %h",
					testName, col, row, expRgb, rgbOut);
				mismatches++;
			end
			if (hSync !== expH) begin
				$display("MISMATCH %s hSync at (%0d,%0d): expected %b, actual %b",
					testName, col, row, expH, hSync);
				mismatches++;
			end
			if (vSync !== expV) begin
				$display("MISMATCH %s vSync at (%0d,%0d): expected %b, actual %b",
					testName, col, row, expV, vSync);
				mismatches++;
			end
			if (frameStart !== (k == 0)) begin
				$display("MISMATCH %s frameStart at (%0d,%0d): expected %b, actual %b",
					testName, col, row, (k == 0), frameStart);
				mismatches++;
			end
			@(negedge clk);
		end
		// the next frame begins exactly one frame period later
		if (frameStart !== 1'b1) begin
			$display("MISMATCH %s frame period: expected frameStart 1, actual %b",
				testName, frameStart);
			mismatches++;
		end
	endtask

	task automatic resetAndSync();
		@(negedge clk);
		if (hSync !== 1'b1) begin
			$display("MISMATCH resetSync hSync after reset: expected 1, actual %b", hSync);
			mismatches++;
		end
		if (vSync !== 1'b1) begin
			$display("MISMATCH resetSync vSync after reset: expected 1, actual %b", vSync);
			mismatches++;
		end
		if (rgbOut !== '0) begin
			$display("MISMATCH resetSync rgbOut after reset: expected %h, actual %h",
				24'h000000, rgbOut);
			mismatches++;
		end
		if (frameStart !== 1'b0) begin
			$display("MISMATCH resetSync frameStart after reset: expected 0, actual %b",
				frameStart);
			mismatches++;
		end
		scanFrame("resetSync");
	endtask

	task automatic backgroundOnly();
		@(posedge clk);
		clearObjects();
		gridColor <= 8'b111_000_11;
		fillColor <= 8'b001_110_00;
		scanFrame("background");
	endtask

	task automatic singleObject();
		@(posedge clk);
		clearObjects();
		placeObject(1, 10, 7, 12, 9, 8'b101_011_10);
		scanFrame("singleObject");
	endtask

	task automatic overlapPriority();
		@(posedge clk);
		placeObject(0, 20, 10, 16, 12, 8'b111_111_11);
		placeObject(1, 14, 6, 16, 14, 8'b100_000_01);
		placeObject(2, 8, 2, 30, 20, 8'b000_101_10);
		scanFrame("priority");
	endtask

	task automatic blankingEdges();
		@(posedge clk);
		// reaches past the right and bottom edges
		placeObject(0, 50, 40, 30, 20, 8'b110_110_01);
		placeObject(1, 0, 0, 0, 0, 8'h00);
		placeObject(2, 0, 0, 80, 54, 8'b011_001_11);
		scanFrame("blanking");
	endtask

	task automatic randomFrames();
		for (int f = 0; f < 3; f++) begin
			@(posedge clk);
			for (int i = 0; i < numObjects; i++) begin
				placeObject(i, randBelow(hTotal), randBelow(vTotal), randBelow(40),
					randBelow(30), rgb8T'($random(seed)));
			end
			gridColor <= rgb8T'($random(seed));
			fillColor <= rgb8T'($random(seed));
			scanFrame("randomFrames");
		end
	endtask

	initial begin
		mismatches = 0;
		otherErrors = 0;
		seed = 32'h9052_40ae;
		resetN = 1'b0;
		gridColor = 8'h00;
		fillColor = 8'h00;
		for (int i = 0; i < numObjects; i++) begin
			objTopLeft[i] = '0;
			objSize[i] = '0;
			objColor[i] = '0;
		end
		repeat (8) @(posedge clk);
		resetN <= 1'b1;
		resetAndSync();
		backgroundOnly();
		singleObject();
		overlapPriority();
		blankingEdges();
		randomFrames();
		$display("errors: %0d mismatches, %0d other failures", mismatches, otherErrors);
		if (mismatches == 0 && otherErrors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/video_checker.sv
// ==============================
// video checker
// bound assertions on blanking, frame start
// and scan position
// ==============================
`default_nettype none

module videoChecker #(
	parameter int hTotal = 800,
	parameter int vTotal = 525
) (
	input logic clk,
	input logic resetN,
	input logic displayEnable,
	input logic hSync,
	input logic vSync,
	input logic frameStart,
	input videoPkg::pixelPosT pixel,
	input videoPkg::rgb24T rgbOut
);
	timeunit 1ns;
	timeprecision 1ns;
	import videoPkg::*;

	// blanking one cycle ago gives black now
	blankBlack: assert property (@(posedge clk) disable iff (!resetN)
		!displayEnable |=> (rgbOut == '0))
		else $error("rgbOut not black after displayEnable was low");

	// frame start sits at pixel (0,0), outside both sync pulses
	frameOutsideSync: assert property (@(posedge clk) disable iff (!resetN)
		frameStart |-> (hSync && vSync))
		else $error("frameStart while a sync pulse is low");

	posInRange: assert property (@(posedge clk) disable iff (!resetN)
		(int'(pixel.x) < hTotal) && (int'(pixel.y) < vTotal))
		else $error("scan position outside the frame");

endmodule

bind videoTop videoChecker #(
	.hTotal(hActive + hFront + hSyncLen + hBack),
	.vTotal(vActive + vFront + vSyncLen + vBack)
) videoCheck (
	.clk(clk),
	.resetN(resetN),
	.displayEnable(displayEnable),
	.hSync(hSync),
	.vSync(vSync),
	.frameStart(frameStart),
	.pixel(pixel),
	.rgbOut(rgbOut)
);

`default_nettype wire

// File: hw/videoTop.sv
// ==============================
// video top
// timing, rectangle drawers, background
// and priority mux, two cycles pixel to output
// ==============================
`default_nettype none

module videoTop #(
	parameter int hActive = 640,
	parameter int hFront = 16,
	parameter int hSyncLen = 96,
	parameter int hBack = 48,
	parameter int vActive = 480,
	parameter int vFront = 10,
	parameter int vSyncLen = 2,
	parameter int vBack = 33,
	parameter int numObjects = 3,
	parameter int gridSpacing = 32
) (
	input logic clk,
	input logic resetN,
	input videoPkg::pixelPosT objTopLeft [numObjects],
	input videoPkg::pixelPosT objSize [numObjects],
	input videoPkg::rgb8T objColor [numObjects],
	input videoPkg::rgb8T gridColor,
	input videoPkg::rgb8T fillColor,
	output logic hSync,
	output logic vSync,
	output logic frameStart,
	output videoPkg::rgb24T rgbOut
);
	import videoPkg::*;

	// current scan position
	pixelPosT pixel;
	// already one stage late, matches drawer outputs
	logic displayEnable;
	objectReqT objects [numObjects];
	rgb8T bgRgb;

	vgaTiming #(
		.hActive(hActive),
		.hFront(hFront),
		.hSyncLen(hSyncLen),
		.hBack(hBack),
		.vActive(vActive),
		.vFront(vFront),
		.vSyncLen(vSyncLen),
		.vBack(vBack)
	) timing (
		.clk(clk),
		.resetN(resetN),
		.pixel(pixel),
		.displayEnable(displayEnable),
		.hSync(hSync),
		.vSync(vSync),
		.frameStart(frameStart)
	);

	// one drawer per object, index 0 on top
	for (genvar i = 0; i < numObjects; i++) begin : drawers
		rectDrawer drawer (
			.clk(clk),
			.resetN(resetN),
			.pixel(pixel),
			.topLeft(objTopLeft[i]),
			.size(objSize[i]),
			.color(objColor[i]),
			.req(objects[i])
		);
	end

	backgroundGen #(
		.gridSpacing(gridSpacing)
	) background (
		.clk(clk),
		.resetN(resetN),
		.pixel(pixel),
		.gridColor(gridColor),
		.fillColor(fillColor),
		.bgRgb(bgRgb)
	);

	objectsMux #(
		.numObjects(numObjects)
	) mux (
		.clk(clk),
		.resetN(resetN),
		.objects(objects),
		.bgRgb(bgRgb),
		.displayEnable(displayEnable),
		.rgbOut(rgbOut)
	);

endmodule

`default_nettype wire

// File: hw/objectsMux.sv
// ==============================
// objects mux
// lowest-index request wins, else background;
// black in blanking, RGB332 to 24 bits
// ==============================
`default_nettype none

module objectsMux #(
	parameter int numObjects = 3
) (
	input logic clk,
	input logic resetN,
	input videoPkg::objectReqT objects [numObjects],
	input videoPkg::rgb8T bgRgb,
	input logic displayEnable,
	output videoPkg::rgb24T rgbOut
);
	import videoPkg::*;

	rgb8T selRgb;
	rgb8T tmpRgb;

	// walk from the lowest priority up, so index 0 is written last
	always_comb begin
		selRgb = bgRgb;
		for (int i = numObjects - 1; i >= 0; i--) begin
			if (objects[i].drawingRequest) begin
				selRgb = objects[i].rgb;
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			tmpRgb <= '0;
		end else if (!displayEnable) begin
			// blanking
			tmpRgb <= '0;
		end else begin
			tmpRgb <= selRgb;
		end
	end

	// widen each channel by repeating its lowest bit
	assign rgbOut.red = {tmpRgb[7:5], {5{tmpRgb[5]}}};
	assign rgbOut.green = {tmpRgb[4:2], {5{tmpRgb[2]}}};
	assign rgbOut.blue = {tmpRgb[1:0], {6{tmpRgb[0]}}};

endmodule

`default_nettype wire

// File: hw/backgroundGen.sv
// ==============================
// background generator
// grid lines every gridSpacing pixels
// over a plain fill colour
// ==============================
`default_nettype none

module backgroundGen #(
	parameter int gridSpacing = 32
) (
	input logic clk,
	input logic resetN,
	input videoPkg::pixelPosT pixel,
	input videoPkg::rgb8T gridColor,
	input videoPkg::rgb8T fillColor,
	output videoPkg::rgb8T bgRgb
);
	import videoPkg::*;

	// gridSpacing is a power of two, so only low bits matter
	localparam int gridBits = $clog2(gridSpacing);

	logic onGridX;
	logic onGridY;
	rgb8T bgReg;

	assign onGridX = (pixel.x[gridBits-1:0] == '0);
	assign onGridY = (pixel.y[gridBits-1:0] == '0);

	// same stage as the drawers
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			bgReg <= '0;
		end else if (onGridX || onGridY) begin
			bgReg <= gridColor;
		end else begin
			bgReg <= fillColor;
		end
	end

	assign bgRgb = bgReg;

endmodule

`default_nettype wire

// File: hw/rectDrawer.sv
// ==============================
// rectangle drawer
// registered request and colour for one
// half-open rectangular object
// ==============================
`default_nettype none

module rectDrawer (
	input logic clk,
	input logic resetN,
	input videoPkg::pixelPosT pixel,
	input videoPkg::pixelPosT topLeft,
	input videoPkg::pixelPosT size,
	input videoPkg::rgb8T color,
	output videoPkg::objectReqT req
);
	import videoPkg::*;

	// one extra bit so an edge past the coordinate range cannot wrap
	logic [11:0] rightEdge;
	logic [11:0] bottomEdge;
	logic insideX;
	logic insideY;
	logic drawReg;
	rgb8T colorReg;

	assign rightEdge = {1'b0, topLeft.x} + {1'b0, size.x};
	assign bottomEdge = {1'b0, topLeft.y} + {1'b0, size.y};

	// left/top inclusive, right/bottom exclusive
	// zero size gives an empty range here
	assign insideX = (pixel.x >= topLeft.x) && ({1'b0, pixel.x} < rightEdge);
	assign insideY = (pixel.y >= topLeft.y) && ({1'b0, pixel.y} < bottomEdge);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			drawReg <= 1'b0;
		end else begin
			drawReg <= insideX && insideY;
		end
	end

	// colour travels with the request, same stage
	always_ff @(posedge clk) begin
		colorReg <= color;
	end

	assign req = '{drawingRequest: drawReg, rgb: colorReg};

endmodule

`default_nettype wire

// File: hw/vgaTiming.sv
// ==============================
// vga timing generator
// scans columns and rows of a frame,
// decodes active-low sync, display enable
// and frame start, aligned to the pipeline
// ==============================
`default_nettype none

module vgaTiming #(
	parameter int hActive = 640,
	parameter int hFront = 16,
	parameter int hSyncLen = 96,
	parameter int hBack = 48,
	parameter int vActive = 480,
	parameter int vFront = 10,
	parameter int vSyncLen = 2,
	parameter int vBack = 33
) (
	input logic clk,
	input logic resetN,
	output videoPkg::pixelPosT pixel,
	output logic displayEnable,
	output logic hSync,
	output logic vSync,
	output logic frameStart
);
	import videoPkg::*;

	localparam int hTotal = hActive + hFront + hSyncLen + hBack;
	localparam int vTotal = vActive + vFront + vSyncLen + vBack;

	// counter-width copies of the decode points
	localparam coordT lastCol = coordT'(hTotal - 1);
	localparam coordT lastRow = coordT'(vTotal - 1);
	localparam coordT hActiveEnd = coordT'(hActive);
	localparam coordT vActiveEnd = coordT'(vActive);
	localparam coordT hSyncStart = coordT'(hActive + hFront);
	localparam coordT hSyncEnd = coordT'(hActive + hFront + hSyncLen);
	localparam coordT vSyncStart = coordT'(vActive + vFront);
	localparam coordT vSyncEnd = coordT'(vActive + vFront + vSyncLen);

	coordT col;
	coordT row;
	logic lineEnd;

	// conditions for the pixel presented this cycle
	logic activeNow;
	logic hSyncNow;
	logic vSyncNow;
	logic frameNow;

	// alignment registers, enable one stage, the rest two
	logic enableDly;
	logic [1:0] hSyncPipe;
	logic [1:0] vSyncPipe;
	logic [1:0] framePipe;

	assign lineEnd = (col == lastCol);

	// column wraps at hTotal, row steps on each wrap
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			col <= '0;
			row <= '0;
		end else if (lineEnd) begin
			col <= '0;
			if (row == lastRow) begin
				row <= '0;
			end else begin
				row <= row + coordT'(1);
			end
		end else begin
			col <= col + coordT'(1);
		end
	end

	assign pixel = '{x: col, y: row};

	assign activeNow = (col < hActiveEnd) && (row < vActiveEnd);
	// sync low inside its window
	assign hSyncNow = !((col >= hSyncStart) && (col < hSyncEnd));
	assign vSyncNow = !((row >= vSyncStart) && (row < vSyncEnd));
	assign frameNow = (col == '0) && (row == '0);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			enableDly <= 1'b0;
			// syncs idle high
			hSyncPipe <= 2'b11;
			vSyncPipe <= 2'b11;
			framePipe <= 2'b00;
		end else begin
			enableDly <= activeNow;
			hSyncPipe <= {hSyncPipe[0], hSyncNow};
			vSyncPipe <= {vSyncPipe[0], vSyncNow};
			framePipe <= {framePipe[0], frameNow};
		end
	end

	// enable feeds the mux, which adds the second stage itself
	assign displayEnable = enableDly;
	assign hSync = hSyncPipe[1];
	assign vSync = vSyncPipe[1];
	assign frameStart = framePipe[1];

endmodule

`default_nettype wire

// File: hw/videoPkg.sv
// ==============================
// video package
// colour, coordinate and per-object
// request types shared by the video blocks
// ==============================
`default_nettype none

package videoPkg;

	// RGB332: red [7:5], green [4:2], blue [1:0]
	typedef logic [7:0] rgb8T;

	// one pixel coordinate or one size value
	typedef logic [10:0] coordT;

	// position, or width/height when used as a size
	typedef struct packed {
		coordT x;
		coordT y;
	} pixelPosT;

	// one drawer's answer for the current pixel
	typedef struct packed {
		logic drawingRequest;
		rgb8T rgb;
	} objectReqT;

	// final 24-bit output colour
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb24T;

endpackage

`default_nettype wire
